// ==== design/eth_config.svh ====
// Ethernet steering core configuration with datapath widths, ethertype codes and queue depths
`ifndef ETH_CONFIG_SVH
`define ETH_CONFIG_SVH

// Payload bits carried per beat
`define ETH_DATA_WIDTH 56

// One byte enable per payload byte
`define ETH_KEEP_WIDTH 7

// Ethertype codes the receive classifier knows
`define ETHERTYPE_IPV4 16'h0800
`define ETHERTYPE_ARP  16'h0806

// Per-branch queue depths, powers of two
`define HDR_FIFO_DEPTH  2
`define BEAT_FIFO_DEPTH 8

`endif

// ==== design/eth_pkg.sv ====
// Ethernet steering types shared by the classifier, queues, arbiter and top level
`include "eth_config.svh"

package eth_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ethertype_t;

    // Full Ethernet header, 112 bits
    typedef struct packed {
        mac_addr_t  dest_mac;
        mac_addr_t  src_mac;
        ethertype_t eth_type;
    } eth_hdr_t;

    // One payload beat, 65 bits
    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
        logic                       user;
    } eth_beat_t;

    // Where the classifier sends the frame in progress
    typedef enum logic [1:0] {
        ROUTE_IDLE = 2'd0,
        ROUTE_IP   = 2'd1,
        ROUTE_ARP  = 2'd2,
        ROUTE_DROP = 2'd3
    } route_t;

endpackage

// ==== design/stream_fifo.sv ====
// Show-ahead synchronous stream queue holding any packed payload type
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int AW = (DEPTH > 2) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            wr_en;
    logic            rd_en;

    assign in_ready  = (count != FULL_COUNT);
    assign out_valid = (count != '0);

    // Head entry shown ahead of the read
    assign out_data = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count moves only when one side transfers alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/eth_type_classifier.sv ====
// Ethertype classifier steering received frames to the IP or ARP branch or discarding them
`timescale 1ns/1ps
`include "eth_config.svh"

module eth_type_classifier (
    input  logic               clk,
    input  logic               rst,

    input  logic               rx_hdr_valid,
    output logic               rx_hdr_ready,
    input  eth_pkg::eth_hdr_t  rx_hdr,
    input  logic               rx_beat_valid,
    output logic               rx_beat_ready,
    input  eth_pkg::eth_beat_t rx_beat,

    output logic               ip_hdr_valid,
    input  logic               ip_hdr_ready,
    output eth_pkg::eth_hdr_t  ip_hdr,
    output logic               ip_beat_valid,
    input  logic               ip_beat_ready,
    output eth_pkg::eth_beat_t ip_beat,

    output logic               arp_hdr_valid,
    input  logic               arp_hdr_ready,
    output eth_pkg::eth_hdr_t  arp_hdr,
    output logic               arp_beat_valid,
    input  logic               arp_beat_ready,
    output eth_pkg::eth_beat_t arp_beat
);
    import eth_pkg::*;

    route_t route_q;
    route_t hdr_route;
    logic   route_idle;
    logic   hdr_fire;
    logic   beat_fire;

    assign route_idle = (route_q == ROUTE_IDLE);

    // Branch selected by the header currently on offer
    always_comb begin
        if (rx_hdr.eth_type == `ETHERTYPE_IPV4) begin
            hdr_route = ROUTE_IP;
        end else if (rx_hdr.eth_type == `ETHERTYPE_ARP) begin
            hdr_route = ROUTE_ARP;
        end else begin
            hdr_route = ROUTE_DROP;
        end
    end

    // Header accepted only between frames, unknown types need no room
    always_comb begin
        case (hdr_route)
            ROUTE_IP:  rx_hdr_ready = route_idle && ip_hdr_ready;
            ROUTE_ARP: rx_hdr_ready = route_idle && arp_hdr_ready;
            default:   rx_hdr_ready = route_idle;
        endcase
    end

    assign ip_hdr_valid  = rx_hdr_valid && route_idle && (hdr_route == ROUTE_IP);
    assign arp_hdr_valid = rx_hdr_valid && route_idle && (hdr_route == ROUTE_ARP);
    assign ip_hdr        = rx_hdr;
    assign arp_hdr       = rx_hdr;

    // Beats follow the latched route
    always_comb begin
        case (route_q)
            ROUTE_IP:   rx_beat_ready = ip_beat_ready;
            ROUTE_ARP:  rx_beat_ready = arp_beat_ready;
            ROUTE_DROP: rx_beat_ready = 1'b1;
            default:    rx_beat_ready = 1'b0;
        endcase
    end

    assign ip_beat_valid  = rx_beat_valid && (route_q == ROUTE_IP);
    assign arp_beat_valid = rx_beat_valid && (route_q == ROUTE_ARP);
    assign ip_beat        = rx_beat;
    assign arp_beat       = rx_beat;

    assign hdr_fire  = rx_hdr_valid && rx_hdr_ready;
    assign beat_fire = rx_beat_valid && rx_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= ROUTE_IDLE;
        end else if (route_idle) begin
            if (hdr_fire) begin
                route_q <= hdr_route;
            end
        end else if (beat_fire && rx_beat.last) begin
            // Frame done, wait for the next header
            route_q <= ROUTE_IDLE;
        end
    end

endmodule

// ==== design/eth_tx_arbiter.sv ====
// Fixed-priority transmit arbiter merging whole ARP and IP frames onto one output
`timescale 1ns/1ps

module eth_tx_arbiter (
    input  logic               clk,
    input  logic               rst,

    input  logic               ip_hdr_valid,
    output logic               ip_hdr_ready,
    input  eth_pkg::eth_hdr_t  ip_hdr,
    input  logic               ip_beat_valid,
    output logic               ip_beat_ready,
    input  eth_pkg::eth_beat_t ip_beat,

    input  logic               arp_hdr_valid,
    output logic               arp_hdr_ready,
    input  eth_pkg::eth_hdr_t  arp_hdr,
    input  logic               arp_beat_valid,
    output logic               arp_beat_ready,
    input  eth_pkg::eth_beat_t arp_beat,

    output logic               tx_hdr_valid,
    input  logic               tx_hdr_ready,
    output eth_pkg::eth_hdr_t  tx_hdr,
    output logic               tx_beat_valid,
    input  logic               tx_beat_ready,
    output eth_pkg::eth_beat_t tx_beat
);

    // Grant state, held for a whole frame
    logic grant_q;
    logic grant_arp_q;
    logic hdr_sent_q;

    logic sel_hdr_valid;
    logic sel_beat_valid;
    logic hdr_phase;
    logic beat_phase;
    logic hdr_fire;
    logic beat_fire;

    assign sel_hdr_valid  = grant_arp_q ? arp_hdr_valid : ip_hdr_valid;
    assign sel_beat_valid = grant_arp_q ? arp_beat_valid : ip_beat_valid;

    // One header first, then the frame's beats
    assign hdr_phase  = grant_q && !hdr_sent_q;
    assign beat_phase = grant_q && hdr_sent_q;

    assign tx_hdr_valid  = hdr_phase && sel_hdr_valid;
    assign tx_hdr        = grant_arp_q ? arp_hdr : ip_hdr;
    assign tx_beat_valid = beat_phase && sel_beat_valid;
    assign tx_beat       = grant_arp_q ? arp_beat : ip_beat;

    // Only the granted source sees the output ready
    assign arp_hdr_ready  = hdr_phase && grant_arp_q && tx_hdr_ready;
    assign ip_hdr_ready   = hdr_phase && !grant_arp_q && tx_hdr_ready;
    assign arp_beat_ready = beat_phase && grant_arp_q && tx_beat_ready;
    assign ip_beat_ready  = beat_phase && !grant_arp_q && tx_beat_ready;

    assign hdr_fire  = tx_hdr_valid && tx_hdr_ready;
    assign beat_fire = tx_beat_valid && tx_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q     <= 1'b0;
            grant_arp_q <= 1'b0;
            hdr_sent_q  <= 1'b0;
        end else if (!grant_q) begin
            hdr_sent_q <= 1'b0;
            if (arp_hdr_valid || ip_hdr_valid) begin
                grant_q     <= 1'b1;
                // ARP wins when both are waiting
                grant_arp_q <= arp_hdr_valid;
            end
        end else begin
            if (hdr_fire) begin
                hdr_sent_q <= 1'b1;
            end
            if (beat_fire && tx_beat.last) begin
                grant_q <= 1'b0;
            end
        end
    end

endmodule

// ==== design/eth_steer_top.sv ====
// Ethernet steering top level with receive classifier, branch queues and transmit arbiter
`timescale 1ns/1ps
`include "eth_config.svh"

module eth_steer_top (
    input  logic               clk,
    input  logic               rst,

    // Received frames
    input  logic               rx_hdr_valid,
    output logic               rx_hdr_ready,
    input  eth_pkg::eth_hdr_t  rx_hdr,
    input  logic               rx_beat_valid,
    output logic               rx_beat_ready,
    input  eth_pkg::eth_beat_t rx_beat,

    // IP receive branch
    output logic               ip_rx_hdr_valid,
    input  logic               ip_rx_hdr_ready,
    output eth_pkg::eth_hdr_t  ip_rx_hdr,
    output logic               ip_rx_beat_valid,
    input  logic               ip_rx_beat_ready,
    output eth_pkg::eth_beat_t ip_rx_beat,

    // ARP receive branch
    output logic               arp_rx_hdr_valid,
    input  logic               arp_rx_hdr_ready,
    output eth_pkg::eth_hdr_t  arp_rx_hdr,
    output logic               arp_rx_beat_valid,
    input  logic               arp_rx_beat_ready,
    output eth_pkg::eth_beat_t arp_rx_beat,

    // Transmit sources
    input  logic               ip_tx_hdr_valid,
    output logic               ip_tx_hdr_ready,
    input  eth_pkg::eth_hdr_t  ip_tx_hdr,
    input  logic               ip_tx_beat_valid,
    output logic               ip_tx_beat_ready,
    input  eth_pkg::eth_beat_t ip_tx_beat,
    input  logic               arp_tx_hdr_valid,
    output logic               arp_tx_hdr_ready,
    input  eth_pkg::eth_hdr_t  arp_tx_hdr,
    input  logic               arp_tx_beat_valid,
    output logic               arp_tx_beat_ready,
    input  eth_pkg::eth_beat_t arp_tx_beat,

    // Merged transmit output
    output logic               tx_hdr_valid,
    input  logic               tx_hdr_ready,
    output eth_pkg::eth_hdr_t  tx_hdr,
    output logic               tx_beat_valid,
    input  logic               tx_beat_ready,
    output eth_pkg::eth_beat_t tx_beat
);
    import eth_pkg::*;

    // Classifier to queue streams
    logic      cls_ip_hdr_valid;
    logic      cls_ip_hdr_ready;
    eth_hdr_t  cls_ip_hdr;
    logic      cls_ip_beat_valid;
    logic      cls_ip_beat_ready;
    eth_beat_t cls_ip_beat;
    logic      cls_arp_hdr_valid;
    logic      cls_arp_hdr_ready;
    eth_hdr_t  cls_arp_hdr;
    logic      cls_arp_beat_valid;
    logic      cls_arp_beat_ready;
    eth_beat_t cls_arp_beat;

    eth_type_classifier u_classifier (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_hdr         (rx_hdr),
        .rx_beat_valid  (rx_beat_valid),
        .rx_beat_ready  (rx_beat_ready),
        .rx_beat        (rx_beat),
        .ip_hdr_valid   (cls_ip_hdr_valid),
        .ip_hdr_ready   (cls_ip_hdr_ready),
        .ip_hdr         (cls_ip_hdr),
        .ip_beat_valid  (cls_ip_beat_valid),
        .ip_beat_ready  (cls_ip_beat_ready),
        .ip_beat        (cls_ip_beat),
        .arp_hdr_valid  (cls_arp_hdr_valid),
        .arp_hdr_ready  (cls_arp_hdr_ready),
        .arp_hdr        (cls_arp_hdr),
        .arp_beat_valid (cls_arp_beat_valid),
        .arp_beat_ready (cls_arp_beat_ready),
        .arp_beat       (cls_arp_beat)
    );

    // IP branch queues
    stream_fifo #(.payload_t(eth_hdr_t), .DEPTH(`HDR_FIFO_DEPTH)) u_ip_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cls_ip_hdr_valid),
        .in_ready  (cls_ip_hdr_ready),
        .in_data   (cls_ip_hdr),
        .out_valid (ip_rx_hdr_valid),
        .out_ready (ip_rx_hdr_ready),
        .out_data  (ip_rx_hdr)
    );

    stream_fifo #(.payload_t(eth_beat_t), .DEPTH(`BEAT_FIFO_DEPTH)) u_ip_beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cls_ip_beat_valid),
        .in_ready  (cls_ip_beat_ready),
        .in_data   (cls_ip_beat),
        .out_valid (ip_rx_beat_valid),
        .out_ready (ip_rx_beat_ready),
        .out_data  (ip_rx_beat)
    );

    // ARP branch queues
    stream_fifo #(.payload_t(eth_hdr_t), .DEPTH(`HDR_FIFO_DEPTH)) u_arp_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cls_arp_hdr_valid),
        .in_ready  (cls_arp_hdr_ready),
        .in_data   (cls_arp_hdr),
        .out_valid (arp_rx_hdr_valid),
        .out_ready (arp_rx_hdr_ready),
        .out_data  (arp_rx_hdr)
    );

    stream_fifo #(.payload_t(eth_beat_t), .DEPTH(`BEAT_FIFO_DEPTH)) u_arp_beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cls_arp_beat_valid),
        .in_ready  (cls_arp_beat_ready),
        .in_data   (cls_arp_beat),
        .out_valid (arp_rx_beat_valid),
        .out_ready (arp_rx_beat_ready),
        .out_data  (arp_rx_beat)
    );

    eth_tx_arbiter u_tx_arbiter (
        .clk            (clk),
        .rst            (rst),
        .ip_hdr_valid   (ip_tx_hdr_valid),
        .ip_hdr_ready   (ip_tx_hdr_ready),
        .ip_hdr         (ip_tx_hdr),
        .ip_beat_valid  (ip_tx_beat_valid),
        .ip_beat_ready  (ip_tx_beat_ready),
        .ip_beat        (ip_tx_beat),
        .arp_hdr_valid  (arp_tx_hdr_valid),
        .arp_hdr_ready  (arp_tx_hdr_ready),
        .arp_hdr        (arp_tx_hdr),
        .arp_beat_valid (arp_tx_beat_valid),
        .arp_beat_ready (arp_tx_beat_ready),
        .arp_beat       (arp_tx_beat),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .tx_hdr         (tx_hdr),
        .tx_beat_valid  (tx_beat_valid),
        .tx_beat_ready  (tx_beat_ready),
        .tx_beat        (tx_beat)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset generator for the Ethernet steering core
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held over the first few rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/eth_steer_assert.sv ====
// Protocol assertions for the Ethernet steering top level, bound into the DUT
`timescale 1ns/1ps

module eth_steer_assert (
    input logic               clk,
    input logic               rst,
    input logic               tx_hdr_valid,
    input logic               tx_hdr_ready,
    input eth_pkg::eth_hdr_t  tx_hdr,
    input logic               tx_beat_valid,
    input logic               tx_beat_ready,
    input eth_pkg::eth_beat_t tx_beat,
    input logic               ip_rx_hdr_valid,
    input logic               ip_rx_beat_valid,
    input logic               ip_rx_beat_ready,
    input eth_pkg::eth_beat_t ip_rx_beat,
    input logic               arp_rx_hdr_valid,
    input logic               arp_rx_beat_valid
);

    logic frame_open;

    // Tx frame open from its header until its last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (tx_beat_valid && tx_beat_ready && tx_beat.last) begin
            frame_open <= 1'b0;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            frame_open <= 1'b1;
        end
    end

    a_valids_after_reset: assert property (@(posedge clk) rst |=> !(tx_hdr_valid
        || tx_beat_valid || ip_rx_hdr_valid || ip_rx_beat_valid || arp_rx_hdr_valid
        || arp_rx_beat_valid))
        else $error("output valid high right after reset");

    a_tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("stalled tx header dropped or changed");

    a_tx_beat_hold: assert property (@(posedge clk) disable iff (rst)
        tx_beat_valid && !tx_beat_ready |=> tx_beat_valid && $stable(tx_beat))
        else $error("stalled tx beat dropped or changed");

    a_ip_beat_hold: assert property (@(posedge clk) disable iff (rst)
        ip_rx_beat_valid && !ip_rx_beat_ready |=> ip_rx_beat_valid && $stable(ip_rx_beat))
        else $error("stalled ip_rx beat dropped or changed");

    a_no_hdr_in_frame: assert property (@(posedge clk) disable iff (rst)
        frame_open |-> !tx_hdr_valid)
        else $error("tx header offered inside an open frame");

endmodule

bind eth_steer_top eth_steer_assert u_assert (.*);

// ==== tests/tb_eth_steer.sv ====
// Testbench for the Ethernet steering core driving frames from a data file
`timescale 1ns/1ps
`include "eth_config.svh"

module tb_eth_steer;
    import eth_pkg::*;

    localparam int TIMEOUT = 2000;

    logic clk, rst;
    logic rx_hdr_valid, rx_hdr_ready, rx_beat_valid, rx_beat_ready;
    logic ip_rx_hdr_valid, ip_rx_hdr_ready, ip_rx_beat_valid, ip_rx_beat_ready;
    logic arp_rx_hdr_valid, arp_rx_hdr_ready, arp_rx_beat_valid, arp_rx_beat_ready;
    logic ip_tx_hdr_valid, ip_tx_hdr_ready, ip_tx_beat_valid, ip_tx_beat_ready;
    logic arp_tx_hdr_valid, arp_tx_hdr_ready, arp_tx_beat_valid, arp_tx_beat_ready;
    logic tx_hdr_valid, tx_hdr_ready, tx_beat_valid, tx_beat_ready;
    eth_hdr_t  rx_hdr, ip_rx_hdr, arp_rx_hdr, ip_tx_hdr, arp_tx_hdr, tx_hdr;
    eth_beat_t rx_beat, ip_rx_beat, arp_rx_beat, ip_tx_beat, arp_tx_beat, tx_beat;

    logic [63:0] fdata [0:255];
    eth_hdr_t  ip_hdr_exp[$], arp_hdr_exp[$], tx_hdr_exp[$];
    eth_beat_t ip_beat_exp[$], arp_beat_exp[$], tx_beat_exp[$];
    int checks = 0;
    int errors = 0;
    int tests = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

    eth_steer_top u_dut (.*);

    function automatic eth_beat_t make_beat(input logic [55:0] first, input int k, input int n);
        eth_beat_t b;
        b.data = first + 56'(k);
        b.keep = '1;
        b.last = (k == n - 1);
        b.user = 1'b0;
        return b;
    endfunction

    function automatic logic ready_of(input int port, input logic is_beat);
        case (port)
            0: return is_beat ? rx_beat_ready : rx_hdr_ready;
            1: return is_beat ? ip_tx_beat_ready : ip_tx_hdr_ready;
            default: return is_beat ? arp_tx_beat_ready : arp_tx_hdr_ready;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic put_hdr(input int port, input logic v, input eth_hdr_t h);
        case (port)
            0: begin
                rx_hdr_valid <= v;
                rx_hdr       <= h;
            end
            1: begin
                ip_tx_hdr_valid <= v;
                ip_tx_hdr       <= h;
            end
            default: begin
                arp_tx_hdr_valid <= v;
                arp_tx_hdr       <= h;
            end
        endcase
    endtask

    task automatic put_beat(input int port, input logic v, input eth_beat_t b);
        case (port)
            0: begin
                rx_beat_valid <= v;
                rx_beat       <= b;
            end
            1: begin
                ip_tx_beat_valid <= v;
                ip_tx_beat       <= b;
            end
            default: begin
                arp_tx_beat_valid <= v;
                arp_tx_beat       <= b;
            end
        endcase
    endtask

    // Returns on the rising edge that completes the transfer
    task automatic wait_accept(input int port, input logic is_beat);
        int t;
        t = 0;
        @(negedge clk);
        while (!ready_of(port, is_beat)) begin
            t++;
            if (t > TIMEOUT) begin
                abort_run($sformatf("timeout: port %0d never accepted a transfer", port));
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic drive_frame(input int port, input eth_hdr_t h, input int n,
                               input logic [55:0] first);
        @(posedge clk);
        put_hdr(port, 1'b1, h);
        wait_accept(port, 1'b0);
        put_hdr(port, 1'b0, h);
        for (int k = 0; k < n; k++) begin
            put_beat(port, 1'b1, make_beat(first, k, n));
            wait_accept(port, 1'b1);
        end
        put_beat(port, 1'b0, '0);
    endtask

    task automatic check_hdr(input string name, ref eth_hdr_t q[$], input eth_hdr_t got);
        checks++;
        if (q.size() == 0) begin
            $display("%s header arrived with none expected at %0t", name, $time);
            errors++;
        end else begin
            if (got !== q[0]) begin
                $display("mismatch at %0t: %s header %h, expected %h", $time, name, got, q[0]);
                errors++;
            end
            void'(q.pop_front());
        end
    endtask

    task automatic check_beat(input string name, ref eth_beat_t q[$], input eth_beat_t got);
        checks++;
        if (q.size() == 0) begin
            $display("%s beat arrived with none expected at %0t", name, $time);
            errors++;
        end else begin
            if (got !== q[0]) begin
                $display("mismatch at %0t: %s beat %h, expected %h", $time, name, got, q[0]);
                errors++;
            end
            void'(q.pop_front());
        end
    endtask

    task automatic wait_drained(input string what);
        int t;
        t = 0;
        while (ip_hdr_exp.size() + ip_beat_exp.size() + arp_hdr_exp.size()
               + arp_beat_exp.size() + tx_hdr_exp.size() + tx_beat_exp.size() != 0) begin
            t++;
            if (t > TIMEOUT) begin
                abort_run($sformatf("timeout: %s frames never all came out", what));
            end
            @(negedge clk);
        end
    endtask

    // Random output back-pressure
    always @(posedge clk) begin
        ip_rx_hdr_ready   <= ($urandom % 4) != 0;
        ip_rx_beat_ready  <= ($urandom % 3) != 0;
        arp_rx_hdr_ready  <= ($urandom % 4) != 0;
        arp_rx_beat_ready <= ($urandom % 3) != 0;
        tx_hdr_ready      <= ($urandom % 3) != 0;
        tx_beat_ready     <= ($urandom % 3) != 0;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (ip_rx_hdr_valid && ip_rx_hdr_ready) check_hdr("ip_rx", ip_hdr_exp, ip_rx_hdr);
            if (ip_rx_beat_valid && ip_rx_beat_ready)
                check_beat("ip_rx", ip_beat_exp, ip_rx_beat);
            if (arp_rx_hdr_valid && arp_rx_hdr_ready) check_hdr("arp_rx", arp_hdr_exp, arp_rx_hdr);
            if (arp_rx_beat_valid && arp_rx_beat_ready)
                check_beat("arp_rx", arp_beat_exp, arp_rx_beat);
            if (tx_hdr_valid && tx_hdr_ready) check_hdr("tx", tx_hdr_exp, tx_hdr);
            if (tx_beat_valid && tx_beat_ready) check_beat("tx", tx_beat_exp, tx_beat);
        end
    end

    initial begin
        int i, t, err0, ip_idx, n;
        eth_hdr_t h;
        void'($urandom(32'h77d3fb1c));
        {rx_hdr_valid, rx_beat_valid, ip_tx_hdr_valid, ip_tx_beat_valid} = '0;
        {arp_tx_hdr_valid, arp_tx_beat_valid} = '0;
        {ip_rx_hdr_ready, ip_rx_beat_ready, arp_rx_hdr_ready, arp_rx_beat_ready} = '0;
        {tx_hdr_ready, tx_beat_ready} = '0;
        {rx_hdr, ip_tx_hdr, arp_tx_hdr} = '0;
        {rx_beat, ip_tx_beat, arp_tx_beat} = '0;
        $readmemh("tests/eth_steer_testdata.txt", fdata);

        t = 0;
        while (rst !== 1'b0) begin
            t++;
            if (t > TIMEOUT) abort_run("timeout: reset never released");
            @(negedge clk);
        end
        // No output may be valid before any input
        repeat (2) begin
            @(negedge clk);
            checks++;
            if (ip_rx_hdr_valid || ip_rx_beat_valid || arp_rx_hdr_valid || arp_rx_beat_valid
                || tx_hdr_valid || tx_beat_valid) begin
                $display("mismatch at %0t: output valid high after reset", $time);
                errors++;
            end
        end
        tests++;
        $display("test reset idle: %0s", errors == 0 ? "ok" : "failed");

        err0 = errors;
        n = 0;
        for (i = 0; fdata[i * 6] == 64'h0; i++) begin
            h = {fdata[i * 6 + 1][47:0], fdata[i * 6 + 2][47:0], fdata[i * 6 + 3][15:0]};
            for (int k = 0; k < int'(fdata[i * 6 + 4]); k++) begin
                if (h.eth_type == `ETHERTYPE_IPV4)
                    ip_beat_exp.push_back(make_beat(fdata[i * 6 + 5][55:0], k,
                                                    int'(fdata[i * 6 + 4])));
                else if (h.eth_type == `ETHERTYPE_ARP)
                    arp_beat_exp.push_back(make_beat(fdata[i * 6 + 5][55:0], k,
                                                     int'(fdata[i * 6 + 4])));
            end
            if (h.eth_type == `ETHERTYPE_IPV4) ip_hdr_exp.push_back(h);
            else if (h.eth_type == `ETHERTYPE_ARP) arp_hdr_exp.push_back(h);
            drive_frame(0, h, int'(fdata[i * 6 + 4]), fdata[i * 6 + 5][55:0]);
            n++;
        end
        wait_drained("rx");
        tests++;
        $display("test rx steering: %0d frames, %0s", n, errors == err0 ? "ok" : "failed");

        // Tx lines come as ip then arp and are offered on the same edge
        for (; fdata[i * 6] != 64'hf; i += 2) begin
            err0 = errors;
            ip_idx = i * 6;
            tx_hdr_exp.push_back({fdata[ip_idx + 7][47:0], fdata[ip_idx + 8][47:0],
                                  fdata[ip_idx + 9][15:0]});
            tx_hdr_exp.push_back({fdata[ip_idx + 1][47:0], fdata[ip_idx + 2][47:0],
                                  fdata[ip_idx + 3][15:0]});
            for (int k = 0; k < int'(fdata[ip_idx + 10]); k++)
                tx_beat_exp.push_back(make_beat(fdata[ip_idx + 11][55:0], k,
                                                int'(fdata[ip_idx + 10])));
            for (int k = 0; k < int'(fdata[ip_idx + 4]); k++)
                tx_beat_exp.push_back(make_beat(fdata[ip_idx + 5][55:0], k,
                                                int'(fdata[ip_idx + 4])));
            fork
                drive_frame(1, tx_hdr_exp[1], int'(fdata[ip_idx + 4]), fdata[ip_idx + 5][55:0]);
                drive_frame(2, tx_hdr_exp[0], int'(fdata[ip_idx + 10]),
                            fdata[ip_idx + 11][55:0]);
            join
            wait_drained("tx");
            tests++;
            $display("test tx pair at line %0d: %0s", i, errors == err0 ? "ok" : "failed");
        end

        repeat (4) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/eth_steer_testdata.txt ====
// dir (0 rx, 1 tx from ip, 2 tx from arp)  dest_mac  src_mac  ethertype  beats  first_data
// tx lines come in ip/arp pairs, a dir of f ends the list
0 0a1b2c3d4e5f 020000000001 0800 3 00000000001000
0 ffffffffffff 020000000002 0806 2 00000000002000
0 0a1b2c3d4e5f 020000000003 86dd 4 00000000003000
0 0a1b2c3d4e5f 020000000004 0800 1 00000000004000
0 0a1b2c3d4e5f 020000000005 0800 5 00000000005000
0 0a1b2c3d4e5f 020000000006 0800 2 00000000006000
0 ffffffffffff 020000000007 0806 3 00000000007000
0 0a1b2c3d4e5f 020000000008 0800 9 00000000008000
1 112233445566 0a1b2c3d4e5f 0800 4 00000000009000
2 ffffffffffff 0a1b2c3d4e5f 0806 2 0000000000a000
1 112233445566 0a1b2c3d4e5f 0800 1 0000000000b000
2 ffffffffffff 0a1b2c3d4e5f 0806 3 0000000000c000
f 0 0 0 0 0

// ==== all.f ====
+incdir+design
design/eth_pkg.sv
design/stream_fifo.sv
design/eth_type_classifier.sv
design/eth_tx_arbiter.sv
design/eth_steer_top.sv
tests/tb_clock_gen.sv
tests/eth_steer_assert.sv
tests/tb_eth_steer.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the Ethernet steering testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_eth_steer --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
else
    exit 1
fi
